//--- src/idStage_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and fixed constants of the ID stage
// Data width is assumed to be 32; the decoder slices fields at fixed bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ID_STAGE_MACROS_SVH
`define ID_STAGE_MACROS_SVH

// Register and data width
`define DATA_W   32
// General register count and address width
`define REG_NUM  32
`define REG_AW   5

// Link register written by JAL, and the return offset past the delay slot
`define LINK_REG 31
`define LINK_OFS 8

// Hazard unit Tnew counter
`define TNEW_W   2

`endif

//--- src/mipsPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction symbols and classes of the supported MIPS subset
// NOP stands for the all-zero word and every unknown encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mipsPkg;

    typedef enum logic [5:0] {
        NOP = 6'd0,
        // Register-register ALU ops
        ADD, SUB, ADDU, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        // Shifts
        SLL, SLLV, SRL, SRLV, SRA, SRAV,
        // Register jumps
        JALR, JR,
        // Immediate ALU ops
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        // Loads
        LW, LH, LHU, LB, LBU,
        // Stores
        SW, SH, SB,
        // Branches
        BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ,
        // Absolute jumps
        J, JAL
    } instrSym;

    // Broad class, used to pick the writeback destination
    typedef enum logic [2:0] {
        none     = 3'd0,
        calcR    = 3'd1,
        calcI    = 3'd2,
        memRead  = 3'd3,
        memWrite = 3'd4,
        branch   = 3'd5,
        jump     = 3'd6
    } instrClass;

endpackage

//--- src/instrDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Purely combinational instruction decoder
// Fields are sliced whatever the format; consumers ignore the unused ones
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "idStage_macros.svh"

module instrDecoder
    import mipsPkg::*;
(
    input  logic [`DATA_W-1:0] code,
    output instrSym            instr,
    output instrClass          cls,
    output logic [`REG_AW-1:0] rsAddr,
    output logic [`REG_AW-1:0] rtAddr,
    output logic [`REG_AW-1:0] rdAddr,
    output logic [4:0]         shamt,
    output logic [15:0]        imm16,
    output logic [25:0]        jmpAddr
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode  = code[31:26];
    assign rsAddr  = code[25:21];
    assign rtAddr  = code[20:16];
    assign rdAddr  = code[15:11];
    assign shamt   = code[10:6];
    assign funct   = code[5:0];
    assign imm16   = code[15:0];
    assign jmpAddr = code[25:0];

    always_comb begin
        instr = NOP;
        if (code == '0) begin
            // sll $0,$0,0 is treated as an explicit bubble
            instr = NOP;
        end else if (opcode == 6'b000000) begin
            case (funct)
                6'b100000: instr = ADD;
                6'b100010: instr = SUB;
                6'b100001: instr = ADDU;
                6'b100011: instr = SUBU;
                6'b100100: instr = AND;
                6'b100101: instr = OR;
                6'b100110: instr = XOR;
                6'b100111: instr = NOR;
                6'b101010: instr = SLT;
                6'b101011: instr = SLTU;
                6'b000000: instr = SLL;
                6'b000100: instr = SLLV;
                6'b000010: instr = SRL;
                6'b000110: instr = SRLV;
                6'b000011: instr = SRA;
                6'b000111: instr = SRAV;
                6'b001001: instr = JALR;
                6'b001000: instr = JR;
                default:   instr = NOP;
            endcase
        end else if (opcode == 6'b000001) begin
            // REGIMM group, rt selects the branch
            case (rtAddr)
                5'd1:    instr = BGEZ;
                5'd0:    instr = BLTZ;
                default: instr = NOP;
            endcase
        end else begin
            case (opcode)
                6'b001000: instr = ADDI;
                6'b001001: instr = ADDIU;
                6'b001100: instr = ANDI;
                6'b001101: instr = ORI;
                6'b001110: instr = XORI;
                6'b001111: instr = LUI;
                6'b001010: instr = SLTI;
                6'b001011: instr = SLTIU;
                6'b100011: instr = LW;
                6'b100001: instr = LH;
                6'b100101: instr = LHU;
                6'b100000: instr = LB;
                6'b100100: instr = LBU;
                6'b101011: instr = SW;
                6'b101001: instr = SH;
                6'b101000: instr = SB;
                6'b000100: instr = BEQ;
                6'b000101: instr = BNE;
                6'b000110: instr = BLEZ;
                6'b000111: instr = BGTZ;
                6'b000010: instr = J;
                6'b000011: instr = JAL;
                default:   instr = NOP;
            endcase
        end
    end

    // Class follows from the symbol alone
    always_comb begin
        case (instr)
            ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
            SLL, SLLV, SRL, SRLV, SRA, SRAV:            cls = calcR;
            ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU: cls = calcI;
            LW, LH, LHU, LB, LBU:                       cls = memRead;
            SW, SH, SB:                                 cls = memWrite;
            BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ:           cls = branch;
            J, JAL, JALR, JR:                           cls = jump;
            default:                                    cls = none;
        endcase
    end

endmodule

//--- src/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// General register file, one write port and two read ports
// A write is attempted every cycle; address zero means no write
// Reads see a same-cycle write through the internal bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "idStage_macros.svh"

module regFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`REG_AW-1:0] wrAddr,
    input  logic [`DATA_W-1:0] wrData,
    input  logic [`REG_AW-1:0] rdAddrA,
    input  logic [`REG_AW-1:0] rdAddrB,
    output logic [`DATA_W-1:0] rdDataA,
    output logic [`DATA_W-1:0] rdDataB
);

    // Register zero has no storage
    logic [`DATA_W-1:0] regs [1:`REG_NUM-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // A matching read address is nonzero, so the write address is too
    assign rdDataA = (rdAddrA == '0)     ? '0     :
                     (rdAddrA == wrAddr) ? wrData :
                                           regs[rdAddrA];

    assign rdDataB = (rdAddrB == '0)     ? '0     :
                     (rdAddrB == wrAddr) ? wrData :
                                           regs[rdAddrB];

endmodule

//--- src/operandUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Source operand fetch with EX and MEM forwarding, plus branch compare
// Forwarding priority is EX, then MEM, then the register file
// Branch signs come from bit 31 of the forwarded rs value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "idStage_macros.svh"

module operandUnit
    import mipsPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  instrSym            instr,
    input  logic [`REG_AW-1:0] rsAddr,
    input  logic [`REG_AW-1:0] rtAddr,
    input  logic [`REG_AW-1:0] exRegAddr,
    input  logic [`DATA_W-1:0] exRegData,
    input  logic [`REG_AW-1:0] memRegAddr,
    input  logic [`DATA_W-1:0] memRegData,
    input  logic [`REG_AW-1:0] wbRegAddr,
    input  logic [`DATA_W-1:0] wbRegData,
    output logic [`DATA_W-1:0] rsData,
    output logic [`DATA_W-1:0] rtData,
    output logic               cmp
);

    logic [`DATA_W-1:0] fileRs;
    logic [`DATA_W-1:0] fileRt;
    logic               rsNeg;
    logic               rsZero;

    // The WB stage writes through the register file itself
    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .wrAddr  (wbRegAddr),
        .wrData  (wbRegData),
        .rdAddrA (rsAddr),
        .rdAddrB (rtAddr),
        .rdDataA (fileRs),
        .rdDataB (fileRt)
    );

    assign rsData = (rsAddr == '0)                             ? '0         :
                    (exRegAddr != '0 && exRegAddr == rsAddr)   ? exRegData  :
                    (memRegAddr != '0 && memRegAddr == rsAddr) ? memRegData :
                                                                 fileRs;

    assign rtData = (rtAddr == '0)                             ? '0         :
                    (exRegAddr != '0 && exRegAddr == rtAddr)   ? exRegData  :
                    (memRegAddr != '0 && memRegAddr == rtAddr) ? memRegData :
                                                                 fileRt;

    assign rsNeg  = rsData[`DATA_W-1];
    assign rsZero = (rsData == '0);

    always_comb begin
        case (instr)
            BEQ:     cmp = (rsData == rtData);
            BNE:     cmp = (rsData != rtData);
            BGEZ:    cmp = ~rsNeg;
            BGTZ:    cmp = ~rsNeg & ~rsZero;
            BLEZ:    cmp = rsNeg | rsZero;
            BLTZ:    cmp = rsNeg;
            default: cmp = 1'b0;
        endcase
    end

endmodule

//--- src/idPipeReg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EX pipeline register with writeback address and early data
// clr loads a bubble and wins over stall; stall holds every output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "idStage_macros.svh"

module idPipeReg
    import mipsPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               clr,
    input  instrSym            instr,
    input  instrClass          cls,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`REG_AW-1:0] rsAddr,
    input  logic [`REG_AW-1:0] rtAddr,
    input  logic [`REG_AW-1:0] rdAddr,
    input  logic [4:0]         shamt,
    input  logic [15:0]        imm16,
    input  logic [`DATA_W-1:0] rsData,
    input  logic [`DATA_W-1:0] rtData,
    input  logic [`TNEW_W-1:0] tNewIn,
    output instrSym            exInstr,
    output logic [`DATA_W-1:0] exPc,
    output logic [`DATA_W-1:0] exRsData,
    output logic [`DATA_W-1:0] exRtData,
    output logic [15:0]        exImm16,
    output logic [4:0]         exShamt,
    output logic [`REG_AW-1:0] exRsAddr,
    output logic [`REG_AW-1:0] exRtAddr,
    output logic [`REG_AW-1:0] exWrAddr,
    output logic [`DATA_W-1:0] exWrData,
    output logic [`TNEW_W-1:0] exTNew
);

    logic [`REG_AW-1:0] wrAddr;
    logic [`DATA_W-1:0] wrData;
    logic [`TNEW_W-1:0] tNewDec;

    assign wrAddr = (instr == JAL)                      ? `REG_AW'(`LINK_REG) :
                    (cls == calcR || instr == JALR)     ? rdAddr :
                    (cls == calcI || cls == memRead)    ? rtAddr :
                                                          '0;

    // Link and LUI values are known here, so EX can forward them early
    assign wrData = (instr == JAL || instr == JALR) ? pc + `DATA_W'(`LINK_OFS) :
                    (instr == LUI)                  ? {imm16, 16'h0000} :
                                                      '0;

    assign tNewDec = (tNewIn == '0) ? '0 : tNewIn - `TNEW_W'(1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exInstr  <= NOP;
            exPc     <= '0;
            exRsData <= '0;
            exRtData <= '0;
            exImm16  <= '0;
            exShamt  <= '0;
            exRsAddr <= '0;
            exRtAddr <= '0;
            exWrAddr <= '0;
            exWrData <= '0;
            exTNew   <= '0;
        end else if (clr) begin
            // Bubble, identical to the reset state
            exInstr  <= NOP;
            exPc     <= '0;
            exRsData <= '0;
            exRtData <= '0;
            exImm16  <= '0;
            exShamt  <= '0;
            exRsAddr <= '0;
            exRtAddr <= '0;
            exWrAddr <= '0;
            exWrData <= '0;
            exTNew   <= '0;
        end else if (!stall) begin
            exInstr  <= instr;
            exPc     <= pc;
            exRsData <= rsData;
            exRtData <= rtData;
            exImm16  <= imm16;
            exShamt  <= shamt;
            exRsAddr <= rsAddr;
            exRtAddr <= rtAddr;
            exWrAddr <= wrAddr;
            exWrData <= wrData;
            exTNew   <= tNewDec;
        end
    end

endmodule

//--- src/idStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decode stage of the five-stage pipeline
// npc* and id* outputs are combinational from code in the same cycle
// ex* outputs are registered; no handshake, stall is the only back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "idStage_macros.svh"

module idStage
    import mipsPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  logic [`DATA_W-1:0] code,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`REG_AW-1:0] exRegAddr,
    input  logic [`DATA_W-1:0] exRegData,
    input  logic [`REG_AW-1:0] memRegAddr,
    input  logic [`DATA_W-1:0] memRegData,
    input  logic [`REG_AW-1:0] wbRegAddr,
    input  logic [`DATA_W-1:0] wbRegData,
    input  logic [`TNEW_W-1:0] tNewIn,
    input  logic               stall,
    input  logic               clr,
    output instrSym            exInstr,
    output logic [`DATA_W-1:0] exPc,
    output logic [`DATA_W-1:0] exRsData,
    output logic [`DATA_W-1:0] exRtData,
    output logic [15:0]        exImm16,
    output logic [4:0]         exShamt,
    output logic [`REG_AW-1:0] exRsAddr,
    output logic [`REG_AW-1:0] exRtAddr,
    output logic [`REG_AW-1:0] exWrAddr,
    output logic [`DATA_W-1:0] exWrData,
    output logic [`TNEW_W-1:0] exTNew,
    output instrSym            npcInstr,
    output logic               npcCmp,
    output logic [15:0]        npcImm16,
    output logic [25:0]        npcJmpAddr,
    output logic [`DATA_W-1:0] npcJmpReg,
    output instrSym            idInstr,
    output logic [`REG_AW-1:0] idRsAddr,
    output logic [`REG_AW-1:0] idRtAddr
);

    instrSym            instr;
    instrClass          cls;
    logic [`REG_AW-1:0] rsAddr;
    logic [`REG_AW-1:0] rtAddr;
    logic [`REG_AW-1:0] rdAddr;
    logic [4:0]         shamt;
    logic [15:0]        imm16;
    logic [`DATA_W-1:0] rsData;
    logic [`DATA_W-1:0] rtData;

    instrDecoder u_decoder (
        .code    (code),
        .instr   (instr),
        .cls     (cls),
        .rsAddr  (rsAddr),
        .rtAddr  (rtAddr),
        .rdAddr  (rdAddr),
        .shamt   (shamt),
        .imm16   (imm16),
        .jmpAddr (npcJmpAddr)
    );

    operandUnit u_operands (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .exRegAddr  (exRegAddr),
        .exRegData  (exRegData),
        .memRegAddr (memRegAddr),
        .memRegData (memRegData),
        .wbRegAddr  (wbRegAddr),
        .wbRegData  (wbRegData),
        .rsData     (rsData),
        .rtData     (rtData),
        .cmp        (npcCmp)
    );

    idPipeReg u_pipeReg (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .clr      (clr),
        .instr    (instr),
        .cls      (cls),
        .pc       (pc),
        .rsAddr   (rsAddr),
        .rtAddr   (rtAddr),
        .rdAddr   (rdAddr),
        .shamt    (shamt),
        .imm16    (imm16),
        .rsData   (rsData),
        .rtData   (rtData),
        .tNewIn   (tNewIn),
        .exInstr  (exInstr),
        .exPc     (exPc),
        .exRsData (exRsData),
        .exRtData (exRtData),
        .exImm16  (exImm16),
        .exShamt  (exShamt),
        .exRsAddr (exRsAddr),
        .exRtAddr (exRtAddr),
        .exWrAddr (exWrAddr),
        .exWrData (exWrData),
        .exTNew   (exTNew)
    );

    // Same-cycle views for next-PC logic and the hazard unit
    assign npcInstr  = instr;
    assign npcImm16  = imm16;
    assign npcJmpReg = rsData;
    assign idInstr   = instr;
    assign idRsAddr  = rsAddr;
    assign idRtAddr  = rtAddr;

endmodule

//--- bench/idChecker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model and output checker for the ID stage
// Same-cycle outputs are compared at the rising edge, ex* at the falling edge
// The shadow register file assumes no writes other than the WB port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "idStage_macros.svh"

module idChecker
    import mipsPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  logic [`DATA_W-1:0] code,
    input  logic [`DATA_W-1:0] pc,
    input  logic [`REG_AW-1:0] exRegAddr,
    input  logic [`DATA_W-1:0] exRegData,
    input  logic [`REG_AW-1:0] memRegAddr,
    input  logic [`DATA_W-1:0] memRegData,
    input  logic [`REG_AW-1:0] wbRegAddr,
    input  logic [`DATA_W-1:0] wbRegData,
    input  logic [`TNEW_W-1:0] tNewIn,
    input  logic               stall,
    input  logic               clr,
    input  instrSym            exInstr,
    input  logic [`DATA_W-1:0] exPc,
    input  logic [`DATA_W-1:0] exRsData,
    input  logic [`DATA_W-1:0] exRtData,
    input  logic [15:0]        exImm16,
    input  logic [4:0]         exShamt,
    input  logic [`REG_AW-1:0] exRsAddr,
    input  logic [`REG_AW-1:0] exRtAddr,
    input  logic [`REG_AW-1:0] exWrAddr,
    input  logic [`DATA_W-1:0] exWrData,
    input  logic [`TNEW_W-1:0] exTNew,
    input  instrSym            npcInstr,
    input  logic               npcCmp,
    input  logic [15:0]        npcImm16,
    input  logic [25:0]        npcJmpAddr,
    input  logic [`DATA_W-1:0] npcJmpReg,
    input  instrSym            idInstr,
    input  logic [`REG_AW-1:0] idRsAddr,
    input  logic [`REG_AW-1:0] idRtAddr,
    output int                 errCount
);

    // Encodings listed in the order of the instrSym enum
    localparam logic [5:0] rFunctTab [18] = '{
        6'h20, 6'h22, 6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a,
        6'h2b, 6'h00, 6'h04, 6'h02, 6'h06, 6'h03, 6'h07, 6'h09, 6'h08
    };
    // Slots 20 and 21 are the REGIMM pair, decoded by rt before the search
    localparam logic [5:0] iOpTab [24] = '{
        6'h08, 6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h0a, 6'h0b,
        6'h23, 6'h21, 6'h25, 6'h20, 6'h24, 6'h2b, 6'h29, 6'h28,
        6'h04, 6'h05, 6'h06, 6'h07, 6'h01, 6'h01, 6'h02, 6'h03
    };

    logic [`DATA_W-1:0] shadow [`REG_NUM];
    int                 checkCount;
    logic               sawClock;

    // Expected contents of the ID/EX register
    instrSym            mInstr;
    logic [`DATA_W-1:0] mPc;
    logic [`DATA_W-1:0] mRsData;
    logic [`DATA_W-1:0] mRtData;
    logic [15:0]        mImm16;
    logic [4:0]         mShamt;
    logic [`REG_AW-1:0] mRsAddr;
    logic [`REG_AW-1:0] mRtAddr;
    logic [`REG_AW-1:0] mWrAddr;
    logic [`DATA_W-1:0] mWrData;
    logic [`TNEW_W-1:0] mTNew;

    function automatic instrSym refDecode(input logic [31:0] w);
        logic [5:0] op;
        logic [5:0] fn;
        op = w[31:26];
        fn = w[5:0];
        if (w == '0) return NOP;
        if (op == 6'd0) begin
            for (int i = 0; i < 18; i++) begin
                if (fn == rFunctTab[i]) return instrSym'(ADD + 6'(i));
            end
            return NOP;
        end
        if (op == 6'd1) begin
            if (w[20:16] == 5'd1) return BGEZ;
            if (w[20:16] == 5'd0) return BLTZ;
            return NOP;
        end
        for (int i = 0; i < 24; i++) begin
            if (op == iOpTab[i]) return instrSym'(ADDI + 6'(i));
        end
        return NOP;
    endfunction

    function automatic instrClass refClass(input instrSym s);
        if (s >= ADD && s <= SRAV) return calcR;
        if (s == JALR || s == JR || s == J || s == JAL) return jump;
        if (s >= ADDI && s <= SLTIU) return calcI;
        if (s >= LW && s <= LBU) return memRead;
        if (s >= SW && s <= SB) return memWrite;
        if (s >= BEQ && s <= BLTZ) return branch;
        return none;
    endfunction

    // EX, then MEM, then the same-cycle WB write, then the stored value
    function automatic logic [31:0] refOperand(input logic [4:0] a);
        if (a == 5'd0) return '0;
        if (a == exRegAddr) return exRegData;
        if (a == memRegAddr) return memRegData;
        if (a == wbRegAddr) return wbRegData;
        return shadow[a];
    endfunction

    function automatic logic refBranch(input instrSym s, input logic [31:0] rs,
                                       input logic [31:0] rt);
        case (s)
            BEQ:     return rs == rt;
            BNE:     return rs != rt;
            BGEZ:    return !rs[31];
            BGTZ:    return !rs[31] && rs != '0;
            BLEZ:    return rs[31] || rs == '0;
            BLTZ:    return rs[31];
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [4:0] refWrAddr(input instrSym s, input logic [31:0] w);
        instrClass c;
        c = refClass(s);
        if (s == JAL) return 5'(`LINK_REG);
        if (c == calcR || s == JALR) return w[15:11];
        if (c == calcI || c == memRead) return w[20:16];
        return '0;
    endfunction

    function automatic logic [31:0] refWrData(input instrSym s, input logic [31:0] w,
                                              input logic [31:0] pcVal);
        if (s == JAL || s == JALR) return pcVal + 32'(`LINK_OFS);
        if (s == LUI) return {w[15:0], 16'h0000};
        return '0;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("FAIL t=%0t %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clearModel();
        mInstr  = NOP;
        mPc     = '0;
        mRsData = '0;
        mRtData = '0;
        mImm16  = '0;
        mShamt  = '0;
        mRsAddr = '0;
        mRtAddr = '0;
        mWrAddr = '0;
        mWrData = '0;
        mTNew   = '0;
    endtask

    task automatic printSummary();
        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
    endtask

    initial begin
        errCount   = 0;
        checkCount = 0;
        sawClock   = 1'b0;
        clearModel();
        for (int i = 0; i < `REG_NUM; i++) begin
            shadow[i] = '0;
        end
    end

    always @(posedge clk) begin : edgeModel
        instrSym            sym;
        logic [`DATA_W-1:0] rsV;
        logic [`DATA_W-1:0] rtV;
        sym = refDecode(code);
        rsV = refOperand(code[25:21]);
        rtV = refOperand(code[20:16]);
        sawClock = 1'b1;
        if (rstN) begin
            checkValue("npcInstr", 32'(npcInstr), 32'(sym));
            checkValue("idInstr", 32'(idInstr), 32'(sym));
            checkValue("idRsAddr", 32'(idRsAddr), 32'(code[25:21]));
            checkValue("idRtAddr", 32'(idRtAddr), 32'(code[20:16]));
            checkValue("npcImm16", 32'(npcImm16), 32'(code[15:0]));
            checkValue("npcJmpAddr", 32'(npcJmpAddr), 32'(code[25:0]));
            checkValue("npcJmpReg", npcJmpReg, rsV);
            checkValue("npcCmp", 32'(npcCmp), 32'(refBranch(sym, rsV, rtV)));
        end
        // Bubble on reset or clr, hold on stall
        if (!rstN || clr) begin
            clearModel();
        end else if (!stall) begin
            mInstr  = sym;
            mPc     = pc;
            mRsData = rsV;
            mRtData = rtV;
            mImm16  = code[15:0];
            mShamt  = code[10:6];
            mRsAddr = code[25:21];
            mRtAddr = code[20:16];
            mWrAddr = refWrAddr(sym, code);
            mWrData = refWrData(sym, code, pc);
            mTNew   = (tNewIn == '0) ? '0 : tNewIn - 2'd1;
        end
        // WB write lands after this edge's reads were evaluated
        if (!rstN) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                shadow[i] = '0;
            end
        end else if (wbRegAddr != '0) begin
            shadow[wbRegAddr] = wbRegData;
        end
    end

    always @(negedge clk) begin
        if (sawClock) begin
            checkValue("exInstr", 32'(exInstr), 32'(mInstr));
            checkValue("exPc", exPc, mPc);
            checkValue("exRsData", exRsData, mRsData);
            checkValue("exRtData", exRtData, mRtData);
            checkValue("exImm16", 32'(exImm16), 32'(mImm16));
            checkValue("exShamt", 32'(exShamt), 32'(mShamt));
            checkValue("exRsAddr", 32'(exRsAddr), 32'(mRsAddr));
            checkValue("exRtAddr", 32'(exRtAddr), 32'(mRtAddr));
            checkValue("exWrAddr", 32'(exWrAddr), 32'(mWrAddr));
            checkValue("exWrData", exWrData, mWrData);
            checkValue("exTNew", 32'(exTNew), 32'(mTNew));
        end
    end

endmodule

//--- bench/idStageTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top-level testbench for the ID stage
// Random but fixed-seed stimulus, driven on the falling clock edge
// Forwarding addresses are biased toward the current rs and rt fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "idStage_macros.svh"

module idStageTb
    import mipsPkg::*;
();

    localparam int numVec      = 3000;
    localparam int resetCycles = 8;
    localparam int clkPeriod   = 40;

    localparam logic [5:0] rFunctList [18] = '{
        6'h20, 6'h22, 6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a,
        6'h2b, 6'h00, 6'h04, 6'h02, 6'h06, 6'h03, 6'h07, 6'h09, 6'h08
    };
    localparam logic [5:0] iOpList [22] = '{
        6'h08, 6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h0a, 6'h0b, 6'h23, 6'h21, 6'h25,
        6'h20, 6'h24, 6'h2b, 6'h29, 6'h28, 6'h04, 6'h05, 6'h06, 6'h07, 6'h02, 6'h03
    };

    logic               clk;
    logic               rstN;
    logic [`DATA_W-1:0] code;
    logic [`DATA_W-1:0] pc;
    logic [`REG_AW-1:0] exRegAddr;
    logic [`DATA_W-1:0] exRegData;
    logic [`REG_AW-1:0] memRegAddr;
    logic [`DATA_W-1:0] memRegData;
    logic [`REG_AW-1:0] wbRegAddr;
    logic [`DATA_W-1:0] wbRegData;
    logic [`TNEW_W-1:0] tNewIn;
    logic               stall;
    logic               clr;
    instrSym            exInstr;
    logic [`DATA_W-1:0] exPc;
    logic [`DATA_W-1:0] exRsData;
    logic [`DATA_W-1:0] exRtData;
    logic [15:0]        exImm16;
    logic [4:0]         exShamt;
    logic [`REG_AW-1:0] exRsAddr;
    logic [`REG_AW-1:0] exRtAddr;
    logic [`REG_AW-1:0] exWrAddr;
    logic [`DATA_W-1:0] exWrData;
    logic [`TNEW_W-1:0] exTNew;
    instrSym            npcInstr;
    logic               npcCmp;
    logic [15:0]        npcImm16;
    logic [25:0]        npcJmpAddr;
    logic [`DATA_W-1:0] npcJmpReg;
    instrSym            idInstr;
    logic [`REG_AW-1:0] idRsAddr;
    logic [`REG_AW-1:0] idRtAddr;
    int                 errCount;

    idStage u_dut (.*);

    idChecker u_checker (.*);

    always #(clkPeriod / 2) clk = ~clk;

    // Supported encodings with random fields, plus zero and unknown words
    function automatic logic [31:0] makeCode();
        int          sel;
        logic [31:0] word;
        sel  = $urandom_range(47, 0);
        word = $urandom;
        if (sel < 18) begin
            word = {6'b000000, word[25:6], rFunctList[sel]};
        end else if (sel < 40) begin
            word = {iOpList[sel - 18], word[25:0]};
        end else if (sel < 42) begin
            word = {6'b000001, word[25:21], 4'b0000, sel[0], word[15:0]};
        end else if (sel < 44) begin
            word = '0;
        end else if (sel < 46) begin
            word = {6'b010000, word[25:0]};
        end else if (sel == 46) begin
            word = {6'b000000, word[25:6], 6'b001100};
        end else begin
            word = {6'b000001, word[25:21], 5'b00010, word[15:0]};
        end
        return word;
    endfunction

    // Sign-boundary values show up often
    function automatic logic [31:0] makeData();
        case ($urandom_range(7, 0))
            0:       return 32'h0000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [4:0] pickAddr(input logic [31:0] word);
        case ($urandom_range(4, 0))
            0, 1:    return 5'd0;
            2:       return word[25:21];
            3:       return word[20:16];
            default: return 5'($urandom);
        endcase
    endfunction

    task automatic driveVector();
        code       = makeCode();
        pc         = ($urandom_range(15, 0) == 0) ? $urandom : pc + 32'd4;
        exRegAddr  = pickAddr(code);
        exRegData  = makeData();
        memRegAddr = pickAddr(code);
        memRegData = makeData();
        wbRegAddr  = pickAddr(code);
        wbRegData  = makeData();
        tNewIn     = 2'($urandom);
        stall      = ($urandom_range(7, 0) == 0);
        clr        = ($urandom_range(15, 0) == 0);
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        code       = '0;
        pc         = '0;
        exRegAddr  = '0;
        exRegData  = '0;
        memRegAddr = '0;
        memRegData = '0;
        wbRegAddr  = '0;
        wbRegData  = '0;
        tNewIn     = '0;
        stall      = 1'b0;
        clr        = 1'b0;
        void'($urandom(67414));
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        repeat (numVec) begin
            driveVector();
            @(negedge clk);
        end
        // Let the last vector reach the EX outputs, then settle between edges
        repeat (2) @(negedge clk);
        #(clkPeriod / 4);
        u_checker.printSummary();
        if (errCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((numVec + resetCycles + 20) * clkPeriod);
        $display("Error: the run timed out before all vectors were applied");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- idStage.f
+incdir+src
src/mipsPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/operandUnit.sv
src/idPipeReg.sv
src/idStage.sv
bench/idChecker.sv
bench/idStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=idStageSim
LOG_FILE=sim.log

if ! verilator --binary --timing -f idStage.f --top-module idStageTb \
        -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Testbench failed" "$LOG_FILE"; then
    exit 1
fi
exit 0
